//--- dv/apb_mem.sv
//##########################################################################
// APB slave memory model with random wait states and byte strobes
//##########################################################################
`timescale 1ns/1ns
`include "ex_config.svh"

module apb_mem (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic [`EX_AW-1:0]   paddr_i,
    input  logic                psel_i,
    input  logic                penable_i,
    input  logic                pwrite_i,
    input  logic [`EX_XLEN-1:0] pwdata_i,
    input  logic [`EX_STRB-1:0] pstrb_i,
    output logic [`EX_XLEN-1:0] prdata_o,
    output logic                pready_o
);
    logic [`EX_XLEN-1:0] mem [64];   // contents loaded by the testbench
    logic [1:0]          wait_q;
    logic [5:0]          idx;

    assign idx      = paddr_i[7:2];
    assign pready_o = penable_i && (wait_q == 2'd0);
    assign prdata_o = mem[idx];

    // 0 to 3 wait states, drawn in the setup cycle
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wait_q <= 2'd0;
        end else if (psel_i && !penable_i) begin
            wait_q <= 2'($urandom_range(3, 0));
        end else if (penable_i && wait_q != 2'd0) begin
            wait_q <= wait_q - 2'd1;
        end
    end

    always @(posedge clk) begin
        if (psel_i && penable_i && pready_o && pwrite_i) begin
            for (int j = 0; j < `EX_STRB; j++) begin
                if (pstrb_i[j])
                    mem[idx][8*j +: 8] <= pwdata_i[8*j +: 8];   // strobed lanes only
            end
        end
    end

endmodule

//--- dv/ex_tb.sv
//##########################################################################
// testbench for the RV32I execute stage with an APB memory model
//##########################################################################
`timescale 1ns/1ns
`include "ex_config.svh"

module ex_tb;
    import ex_pkg::*;

    logic                clk = 1'b0;
    logic                rst_n_i;
    logic                valid_i;
    logic [31:0]         inst_i;
    word_t               pc_i;
    word_t               rs1_data_i;
    word_t               rs2_data_i;
    logic                ready_o;
    logic                wb_valid_o;
    logic [4:0]          wb_rd_o;
    word_t               wb_data_o;
    logic                jump_o;
    word_t               jump_addr_o;
    logic [`EX_AW-1:0]   paddr_o;
    logic                psel_o;
    logic                penable_o;
    logic                pwrite_o;
    word_t               pwdata_o;
    logic [`EX_STRB-1:0] pstrb_o;
    word_t               prdata;
    logic                pready;

    // expected response of the instruction in flight
    string               test_name;
    logic                exp_wb;
    logic                exp_jump;
    logic                exp_mem;
    logic                exp_write;
    logic [4:0]          exp_rd;
    word_t               exp_data;
    word_t               exp_jaddr;
    word_t               exp_paddr;
    word_t               exp_wdata;
    logic [`EX_STRB-1:0] exp_strb;
    word_t               exp_mask;
    word_t               model_mem [64];
    logic                acc_alu;
    logic                acc_mem;
    logic                apb_done;

    always #5 clk = ~clk;

    ex_top i_ex_top (
        .clk, .rst_n_i, .valid_i, .inst_i, .pc_i, .rs1_data_i, .rs2_data_i,
        .ready_o, .wb_valid_o, .wb_rd_o, .wb_data_o, .jump_o, .jump_addr_o,
        .paddr_o, .psel_o, .penable_o, .pwrite_o, .pwdata_o, .pstrb_o,
        .prdata_i (prdata),
        .pready_i (pready)
    );

    apb_mem i_apb_mem (
        .clk, .rst_n_i,
        .paddr_i (paddr_o), .psel_i (psel_o), .penable_i (penable_o), .pwrite_i (pwrite_o),
        .pwdata_i (pwdata_o), .pstrb_i (pstrb_o), .prdata_o (prdata), .pready_o (pready)
    );

    assign acc_alu  = valid_i && ready_o && !exp_mem;
    assign acc_mem  = valid_i && ready_o && exp_mem;
    assign apb_done = penable_o && pready;
    assign exp_mask = {{8{exp_strb[3]}}, {8{exp_strb[2]}}, {8{exp_strb[1]}}, {8{exp_strb[0]}}};

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    function automatic word_t sx(input word_t v, input int w);
        return word_t'($signed(v << (32 - w)) >>> (32 - w));
    endfunction

    function automatic word_t fill_word(input int i);
        return (i * 32'h9e3779b1) ^ 32'h5a5a0000 ^ i;
    endfunction

    function automatic logic lt_signed(input word_t a, input word_t b);
        return (a[31] != b[31]) ? a[31] : (a < b);
    endfunction

    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'd0, lt_signed(a, b)};
            3'd3:    return {31'd0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return (alt && a[31]) ? ~(~a >> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return lt_signed(a, b);
            3'd5:    return !lt_signed(a, b);
            3'd6:    return a < b;
            default: return !(a < b);
        endcase
    endfunction

    task automatic expect_none();
        exp_wb    = 1'b0;
        exp_jump  = 1'b0;
        exp_mem   = 1'b0;
        exp_write = 1'b0;
        exp_rd    = 5'd0;
        exp_data  = '0;
        exp_jaddr = '0;
        exp_paddr = '0;
        exp_wdata = '0;
        exp_strb  = '0;
    endtask

    task automatic store_expect(input logic [2:0] f3, input word_t addr, input word_t data);
        int j;
        expect_none();
        exp_mem   = 1'b1;
        exp_write = 1'b1;
        exp_paddr = {addr[31:2], 2'b00};
        exp_strb  = (f3 == 3'd0) ? 4'b0001 : ((f3 == 3'd1) ? 4'b0011 : 4'b1111);
        exp_strb  = exp_strb << addr[1:0];
        exp_wdata = data << (8 * addr[1:0]);
        for (j = 0; j < 4; j++) begin
            if (exp_strb[j])
                model_mem[addr[7:2]][8*j +: 8] = exp_wdata[8*j +: 8];
        end
    endtask

    task automatic load_expect(input logic [2:0] f3, input word_t addr, input logic [4:0] rd);
        word_t lane;
        expect_none();
        lane      = model_mem[addr[7:2]] >> (8 * addr[1:0]);
        exp_mem   = 1'b1;
        exp_paddr = {addr[31:2], 2'b00};
        exp_wb    = 1'b1;
        exp_rd    = rd;
        case (f3)
            3'd0:    exp_data = sx(lane, 8);
            3'd1:    exp_data = sx(lane, 16);
            3'd4:    exp_data = lane & 32'hff;
            3'd5:    exp_data = lane & 32'hffff;
            default: exp_data = lane;
        endcase
    endtask

    // one instruction, then wait until the stage is free again
    task automatic issue(input string name, input logic [31:0] inst, input word_t pc,
                         input word_t a, input word_t b);
        int n;
        test_name  = name;
        inst_i     = inst;
        pc_i       = pc;
        rs1_data_i = a;
        rs2_data_i = b;
        valid_i    = 1'b1;
        @(posedge clk);
        #1 valid_i = 1'b0;
        for (n = 0; n < 20 && !ready_o; n++) begin
            @(posedge clk);
            #1;
        end
        if (!ready_o)
            report_fail($sformatf("%s: ready_o did not return within 20 cycles", name));
        repeat (2) begin
            @(posedge clk);
            #1;
        end
    endtask

    assert property (@(posedge clk) (!rst_n_i || !$past(rst_n_i)) |->
                     {ready_o, wb_valid_o, jump_o, psel_o, penable_o} == 5'b10000)
        else report_fail($sformatf("FAIL reset: outputs expected %b actual %b", 5'b10000,
                         $sampled({ready_o, wb_valid_o, jump_o, psel_o, penable_o})));
    assert property (@(posedge clk) disable iff (!rst_n_i) acc_alu |=> wb_valid_o == exp_wb)
        else report_fail($sformatf("FAIL %s: wb_valid expected %0d actual %0d",
                         test_name, exp_wb, $sampled(wb_valid_o)));
    assert property (@(posedge clk) disable iff (!rst_n_i) acc_alu |=> jump_o == exp_jump)
        else report_fail($sformatf("FAIL %s: jump expected %0d actual %0d",
                         test_name, exp_jump, $sampled(jump_o)));
    assert property (@(posedge clk) disable iff (!rst_n_i)
                     (acc_alu || apb_done) && exp_wb |=> {wb_rd_o, wb_data_o} == {exp_rd, exp_data})
        else report_fail($sformatf("FAIL %s: rd/data expected %h actual %h",
                         test_name, {exp_rd, exp_data}, $sampled({wb_rd_o, wb_data_o})));
    assert property (@(posedge clk) disable iff (!rst_n_i)
                     acc_alu && exp_jump |=> jump_addr_o == exp_jaddr)
        else report_fail($sformatf("FAIL %s: jump_addr expected %h actual %h",
                         test_name, exp_jaddr, $sampled(jump_addr_o)));
    assert property (@(posedge clk) disable iff (!rst_n_i) wb_valid_o |=> !wb_valid_o)
        else report_fail($sformatf("%s: wb_valid_o stayed high for two cycles", test_name));
    assert property (@(posedge clk) disable iff (!rst_n_i)
                     acc_mem |=> psel_o && !penable_o && !ready_o && !wb_valid_o)
        else report_fail($sformatf("%s: no APB setup cycle right after acceptance", test_name));
    assert property (@(posedge clk) disable iff (!rst_n_i) psel_o && !penable_o |->
                     {pwrite_o, pstrb_o, paddr_o} == {exp_write, exp_strb, exp_paddr})
        else report_fail($sformatf("FAIL %s: write/strb/addr expected %h actual %h", test_name,
                         {exp_write, exp_strb, exp_paddr}, $sampled({pwrite_o, pstrb_o, paddr_o})));
    assert property (@(posedge clk) disable iff (!rst_n_i) psel_o && !penable_o |->
                     (pwdata_o & exp_mask) == (exp_wdata & exp_mask))
        else report_fail($sformatf("FAIL %s: strobed pwdata expected %h actual %h", test_name,
                         exp_wdata & exp_mask, $sampled(pwdata_o) & exp_mask));
    // access follows setup and holds until pready
    assert property (@(posedge clk) disable iff (!rst_n_i) psel_o && !apb_done |=>
                     psel_o && penable_o && $stable(paddr_o) && $stable(pwdata_o)
                     && $stable(pstrb_o))
        else report_fail($sformatf("%s: APB phase order or held values broken", test_name));
    assert property (@(posedge clk) disable iff (!rst_n_i) psel_o |-> !ready_o)
        else report_fail($sformatf("%s: ready_o high during an APB transfer", test_name));
    assert property (@(posedge clk) disable iff (!rst_n_i)
                     apb_done |=> ready_o && !psel_o && wb_valid_o == exp_wb)
        else report_fail($sformatf("FAIL %s: ready/psel/wb_valid expected %b actual %b",
                         test_name, {1'b1, 1'b0, exp_wb},
                         $sampled({ready_o, psel_o, wb_valid_o})));

    initial begin
        word_t      a;
        word_t      b;
        word_t      pc;
        word_t      imm;
        word_t      addr;
        logic [2:0] f3;
        logic [4:0] rd;
        logic       alt;
        int         k;
        void'($urandom(37));
        rst_n_i    = 1'b1;
        valid_i    = 1'b0;
        inst_i     = '0;
        pc_i       = '0;
        rs1_data_i = '0;
        rs2_data_i = '0;
        expect_none();
        for (k = 0; k < 64; k++) begin
            model_mem[k]       = fill_word(k);
            i_apb_mem.mem[k]   = fill_word(k);
        end
        #1 rst_n_i = 1'b0;
        repeat (8) @(posedge clk);
        #1 rst_n_i = 1'b1;
        @(posedge clk);
        #1;

        for (k = 0; k < 40; k++) begin
            a   = $urandom;
            b   = $urandom;
            pc  = $urandom & ~32'd3;
            f3  = 3'(k / 2);
            rd  = 5'($urandom);
            alt = (k >= 16) && (f3 == 3'd0 || f3 == 3'd5);   // sub or sra
            expect_none();
            exp_wb = 1'b1;
            exp_rd = rd;
            if (k % 2 == 0) begin
                exp_data = alu_ref(f3, alt, a, b);
                issue("op", {1'b0, alt, 5'd0, 5'd2, 5'd1, f3, rd, 7'h33}, pc, a, b);
            end else begin
                alt      = alt && f3 == 3'd5;
                imm      = (f3 == 3'd1 || f3 == 3'd5) ? {21'd0, alt, 5'd0, b[4:0]} : sx(b, 12);
                exp_data = alu_ref(f3, alt, a, imm);
                issue("op_imm", {imm[11:0], 5'd1, f3, rd, 7'h13}, pc, a, b);
            end
        end

        for (k = 0; k < 8; k++) begin
            a   = $urandom;
            imm = $urandom;
            pc  = $urandom & ~32'd3;
            rd  = 5'($urandom);
            expect_none();
            exp_wb   = 1'b1;
            exp_rd   = rd;
            exp_data = {imm[31:12], 12'd0};
            issue("lui", {imm[31:12], rd, 7'h37}, pc, a, 32'd0);
            exp_data = pc + {imm[31:12], 12'd0};
            issue("auipc", {imm[31:12], rd, 7'h17}, pc, a, 32'd0);
            exp_jump  = 1'b1;
            exp_data  = pc + 32'd4;
            exp_jaddr = pc + sx({imm[20:1], 1'b0}, 21);
            issue("jal", {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f}, pc, a, 32'd0);
            exp_jaddr = (a + sx(imm, 12)) & ~32'd1;
            issue("jalr", {imm[11:0], 5'd1, 3'd0, rd, 7'h67}, pc, a, 32'd0);
        end

        for (k = 0; k < 36; k++) begin
            f3  = (k % 6 < 2) ? 3'(k % 6) : 3'(k % 6 + 2);
            a   = $urandom;
            b   = ($urandom % 3 == 0) ? a : $urandom;   // equal operands now and then
            pc  = $urandom & ~32'd3;
            imm = $urandom & 32'h1ffe;
            expect_none();
            exp_jump  = branch_ref(f3, a, b);
            exp_jaddr = pc + sx(imm, 13);
            issue($sformatf("branch f3=%0d", f3),
                  {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'h63}, pc, a, b);
        end

        for (k = 0; k < 24; k++) begin
            f3   = 3'(k % 3);
            addr = word_t'($urandom_range(255, 0)) & ~((32'd1 << f3) - 32'd1);
            imm  = word_t'($urandom_range(63, 0)) - 32'd32;
            a    = addr - imm;
            b    = $urandom;
            pc   = $urandom & ~32'd3;
            rd   = 5'($urandom);
            store_expect(f3, addr, b);
            issue($sformatf("store f3=%0d", f3),
                  {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], 7'h23}, pc, a, b);
            // read the whole word back
            load_expect(3'd2, {addr[31:2], 2'b00}, rd);
            issue("lw_after_store", {imm[11:0], 5'd1, 3'd2, rd, 7'h03}, pc,
                  a - addr[1:0], 32'd0);
        end

        for (k = 0; k < 30; k++) begin
            f3   = (k % 5 < 3) ? 3'(k % 5) : 3'(k % 5 + 1);
            addr = word_t'($urandom_range(255, 0)) & ~((32'd1 << f3[1:0]) - 32'd1);
            imm  = word_t'($urandom_range(63, 0)) - 32'd32;
            a    = addr - imm;
            pc   = $urandom & ~32'd3;
            rd   = 5'($urandom);
            load_expect(f3, addr, rd);
            issue($sformatf("load f3=%0d", f3), {imm[11:0], 5'd1, f3, rd, 7'h03}, pc, a, 32'd0);
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- list.f
+incdir+src
src/ex_pkg.sv
src/ex_ifs.sv
src/ex_ctrl.sv
src/ex_alu.sv
src/ex_branch.sv
src/ex_lsu.sv
src/ex_top.sv
dv/apb_mem.sv
dv/ex_tb.sv

//--- src/ex_alu.sv
//##########################################################################
// integer ALU for RV32I arithmetic, logic, compare and shifts
//##########################################################################
`timescale 1ns/1ns

module ex_alu (
    alu_if.alu alu
);
    import ex_pkg::*;

    logic [4:0] shamt;
    word_t      sum;
    word_t      diff;
    logic       lt_s;
    logic       lt_u;

    assign shamt = alu.op_b[4:0];   // RV32I uses five shift bits
    assign sum   = alu.op_a + alu.op_b;
    assign diff  = alu.op_a - alu.op_b;
    assign lt_s  = $signed(alu.op_a) < $signed(alu.op_b);
    assign lt_u  = alu.op_a < alu.op_b;

    always_comb begin
        case (alu.op)
            ALU_ADD:    alu.result = sum;
            ALU_SUB:    alu.result = diff;
            ALU_SLL:    alu.result = alu.op_a << shamt;
            ALU_SLT:    alu.result = word_t'(lt_s);
            ALU_SLTU:   alu.result = word_t'(lt_u);
            ALU_XOR:    alu.result = alu.op_a ^ alu.op_b;
            ALU_SRL:    alu.result = alu.op_a >> shamt;
            ALU_SRA:    alu.result = word_t'($signed(alu.op_a) >>> shamt);   // sign fill
            ALU_OR:     alu.result = alu.op_a | alu.op_b;
            ALU_AND:    alu.result = alu.op_a & alu.op_b;
            ALU_PASS_B: alu.result = alu.op_b;
            default:    alu.result = '0;
        endcase
    end

endmodule

//--- src/ex_branch.sv
//##########################################################################
// branch condition check and jump target adder
//##########################################################################
`timescale 1ns/1ns

module ex_branch (
    br_if.branch br
);
    import ex_pkg::*;

    logic  eq;
    logic  lt_s;
    logic  lt_u;
    logic  cond;
    word_t pc_sum;
    word_t rs1_sum;

    assign eq      = (br.rs1 == br.rs2);
    assign lt_s    = $signed(br.rs1) < $signed(br.rs2);
    assign lt_u    = br.rs1 < br.rs2;
    assign pc_sum  = br.pc + br.imm;
    assign rs1_sum = br.rs1 + br.imm;

    always_comb begin
        case (br.funct3)
            3'b000:  cond = eq;       // beq
            3'b001:  cond = ~eq;
            3'b100:  cond = lt_s;     // blt
            3'b101:  cond = ~lt_s;
            3'b110:  cond = lt_u;
            3'b111:  cond = ~lt_u;
            default: cond = 1'b0;
        endcase
    end

    assign br.taken  = (br.kind == BR_COND) ? cond : (br.kind != BR_NONE);
    assign br.target = (br.kind == BR_JALR) ? {rs1_sum[$bits(word_t)-1:1], 1'b0} : pc_sum;

endmodule

//--- src/ex_config.svh
//##########################################################################
// execute stage width settings
//##########################################################################
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// data path word
`define EX_XLEN 32
// APB address
`define EX_AW   32
`define EX_STRB (`EX_XLEN / 8)

`endif

//--- src/ex_ctrl.sv
//##########################################################################
// execute control: decode, issue/busy FSM, writeback and jump registers
//##########################################################################
`timescale 1ns/1ns

module ex_ctrl (
    input  logic          clk,
    input  logic          rst_n_i,
    input  logic          valid_i,
    input  ex_pkg::inst_t inst_i,
    input  ex_pkg::word_t pc_i,
    input  ex_pkg::word_t rs1_data_i,
    input  ex_pkg::word_t rs2_data_i,
    output logic          ready_o,
    output logic          wb_valid_o,
    output logic [4:0]    wb_rd_o,
    output ex_pkg::word_t wb_data_o,
    output logic          jump_o,
    output ex_pkg::word_t jump_addr_o,
    alu_if.ctrl           alu,
    br_if.ctrl            br,
    lsu_if.ctrl           lsu
);
    import ex_pkg::*;

    typedef enum logic {IDLE, MEM_WAIT} state_e;

    state_e  state_q;
    opcode_e opc;
    word_t   imm_i;
    word_t   imm_s;
    word_t   imm_b;
    word_t   imm_u;
    word_t   imm_j;
    logic    accept;
    logic    is_mem;
    logic    writes_rd;
    logic    load_q;

    assign opc   = opcode_e'(inst_i.r_fmt.opcode);
    assign imm_i = {{20{inst_i.i_fmt.imm12[11]}}, inst_i.i_fmt.imm12};
    assign imm_s = {{20{inst_i.r_fmt.funct7[6]}}, inst_i.r_fmt.funct7, inst_i.r_fmt.rd};
    assign imm_b = {{20{inst_i.r_fmt.funct7[6]}}, inst_i.r_fmt.rd[0],
                    inst_i.r_fmt.funct7[5:0], inst_i.r_fmt.rd[4:1], 1'b0};
    assign imm_u = {inst_i.r_fmt.funct7, inst_i.r_fmt.rs2, inst_i.r_fmt.rs1,
                    inst_i.r_fmt.funct3, 12'b0};
    assign imm_j = {{12{inst_i.r_fmt.funct7[6]}}, inst_i.r_fmt.rs1, inst_i.r_fmt.funct3,
                    inst_i.r_fmt.rs2[0], inst_i.r_fmt.funct7[5:0], inst_i.r_fmt.rs2[4:1], 1'b0};

    assign is_mem    = opc inside {LOAD, STORE};
    assign writes_rd = opc inside {OP_IMM, OP, LUI, AUIPC, JAL, JALR};
    assign ready_o   = (state_q == IDLE);
    assign accept    = valid_i & ready_o;

    assign alu.op_a = (opc == AUIPC) ? pc_i : rs1_data_i;

    always_comb begin
        case (opc)
            OP:          alu.op_b = rs2_data_i;
            LUI, AUIPC:  alu.op_b = imm_u;
            STORE:       alu.op_b = imm_s;
            default:     alu.op_b = imm_i;   // OP-IMM and load address
        endcase
        alu.op = (opc == LUI) ? ALU_PASS_B : ALU_ADD;
        if (opc == OP || opc == OP_IMM) begin
            case (inst_i.r_fmt.funct3)
                3'b000:  alu.op = (opc == OP && inst_i.r_fmt.funct7[5]) ? ALU_SUB : ALU_ADD;
                3'b001:  alu.op = ALU_SLL;
                3'b010:  alu.op = ALU_SLT;
                3'b011:  alu.op = ALU_SLTU;
                3'b100:  alu.op = ALU_XOR;
                3'b101:  alu.op = inst_i.r_fmt.funct7[5] ? ALU_SRA : ALU_SRL;
                3'b110:  alu.op = ALU_OR;
                default: alu.op = ALU_AND;
            endcase
        end
    end

    always_comb begin
        case (opc)
            BRANCH:  br.kind = BR_COND;
            JAL:     br.kind = BR_JAL;
            JALR:    br.kind = BR_JALR;
            default: br.kind = BR_NONE;
        endcase
    end

    assign br.funct3 = inst_i.r_fmt.funct3;
    assign br.rs1    = rs1_data_i;
    assign br.rs2    = rs2_data_i;
    assign br.pc     = pc_i;
    assign br.imm    = (opc == BRANCH) ? imm_b : ((opc == JAL) ? imm_j : imm_i);

    assign lsu.req   = accept & is_mem;
    assign lsu.write = (opc == STORE);
    assign lsu.addr  = alu.result;   // rs1 plus offset
    assign lsu.wdata = rs2_data_i;
    assign lsu.size  = ls_size_e'(inst_i.r_fmt.funct3[1:0]);
    assign lsu.uns   = inst_i.r_fmt.funct3[2];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= IDLE;
            wb_valid_o <= 1'b0;
            jump_o     <= 1'b0;
        end else begin
            wb_valid_o <= 1'b0;
            jump_o     <= 1'b0;
            if (state_q == IDLE && accept) begin
                state_q    <= is_mem ? MEM_WAIT : IDLE;
                wb_valid_o <= writes_rd;
                jump_o     <= br.taken;
            end else if (state_q == MEM_WAIT && lsu.done) begin
                state_q    <= IDLE;
                wb_valid_o <= load_q;   // stores write nothing back
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            load_q      <= (opc == LOAD);
            wb_rd_o     <= inst_i.r_fmt.rd;
            wb_data_o   <= (opc inside {JAL, JALR}) ? pc_i + 4 : alu.result;
            jump_addr_o <= br.target;
        end else if (lsu.done) begin
            wb_data_o <= lsu.rdata;
        end
    end

endmodule

//--- src/ex_ifs.sv
//##########################################################################
// internal buses between execute control and its datapath units
//##########################################################################
`timescale 1ns/1ns
`include "ex_config.svh"

interface alu_if;
    ex_pkg::word_t   op_a;
    ex_pkg::word_t   op_b;
    ex_pkg::alu_op_e op;
    ex_pkg::word_t   result;

    modport ctrl (output op_a, output op_b, output op, input result);
    modport alu (input op_a, input op_b, input op, output result);
endinterface

interface br_if;
    ex_pkg::br_kind_e kind;
    logic [2:0]       funct3;
    ex_pkg::word_t    rs1;
    ex_pkg::word_t    rs2;
    ex_pkg::word_t    pc;
    ex_pkg::word_t    imm;
    logic             taken;
    ex_pkg::word_t    target;

    modport ctrl (output kind, funct3, rs1, rs2, pc, imm, input taken, target);
    modport branch (input kind, funct3, rs1, rs2, pc, imm, output taken, target);
endinterface

interface lsu_if;
    logic                req;     // single cycle, never before done
    logic                write;
    logic [`EX_AW-1:0]   addr;
    ex_pkg::word_t       wdata;
    ex_pkg::ls_size_e    size;
    logic                uns;
    logic                done;
    ex_pkg::word_t       rdata;   // already extended

    modport ctrl (output req, write, addr, wdata, size, uns, input done, rdata);
    modport lsu (input req, write, addr, wdata, size, uns, output done, rdata);
endinterface

//--- src/ex_lsu.sv
//##########################################################################
// load/store unit, APB master with byte-lane steering and load extension
//##########################################################################
`timescale 1ns/1ns
`include "ex_config.svh"

module ex_lsu (
    input  logic                clk,
    input  logic                rst_n_i,
    lsu_if.lsu                  lsu,
    output logic [`EX_AW-1:0]   paddr_o,
    output logic                psel_o,
    output logic                penable_o,
    output logic                pwrite_o,
    output ex_pkg::word_t       pwdata_o,
    output logic [`EX_STRB-1:0] pstrb_o,
    input  ex_pkg::word_t       prdata_i,
    input  logic                pready_i
);
    import ex_pkg::*;

    ls_size_e            size_q;
    logic                uns_q;
    logic [1:0]          off_q;
    word_t               lane;
    word_t               wdata_rep;
    logic [`EX_STRB-1:0] strb;

    // store data goes to every lane, the strobe picks the live ones
    always_comb begin
        case (lsu.size)
            LS_BYTE: begin
                wdata_rep = {`EX_STRB{lsu.wdata[7:0]}};
                strb      = `EX_STRB'(1) << lsu.addr[1:0];
            end
            LS_HALF: begin
                wdata_rep = {(`EX_STRB / 2){lsu.wdata[15:0]}};
                strb      = `EX_STRB'(3) << {lsu.addr[1], 1'b0};
            end
            default: begin
                wdata_rep = lsu.wdata;
                strb      = '1;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            psel_o    <= 1'b0;
            penable_o <= 1'b0;
            pwrite_o  <= 1'b0;
        end else if (lsu.req) begin
            psel_o   <= 1'b1;   // setup phase
            pwrite_o <= lsu.write;
        end else if (psel_o && !penable_o) begin
            penable_o <= 1'b1;
        end else if (penable_o && pready_i) begin
            psel_o    <= 1'b0;
            penable_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (lsu.req) begin
            paddr_o  <= {lsu.addr[`EX_AW-1:2], 2'b00};
            pwdata_o <= wdata_rep;
            pstrb_o  <= lsu.write ? strb : '0;
            size_q   <= lsu.size;
            uns_q    <= lsu.uns;
            off_q    <= lsu.addr[1:0];
        end
    end

    assign lane     = prdata_i >> {off_q, 3'b000};
    assign lsu.done = penable_o & pready_i;

    always_comb begin
        case (size_q)
            LS_BYTE: lsu.rdata = {{(`EX_XLEN - 8){lane[7] & ~uns_q}}, lane[7:0]};
            LS_HALF: lsu.rdata = {{(`EX_XLEN - 16){lane[15] & ~uns_q}}, lane[15:0]};
            default: lsu.rdata = prdata_i;
        endcase
    end

endmodule

//--- src/ex_pkg.sv
//##########################################################################
// execute stage types: opcodes, ALU operations, instruction formats
//##########################################################################
`include "ex_config.svh"

package ex_pkg;

    typedef logic [`EX_XLEN-1:0] word_t;

    // RV32I major opcodes kept by this stage
    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011
    } opcode_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } inst_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {BR_NONE, BR_COND, BR_JAL, BR_JALR} br_kind_e;

    typedef enum logic [1:0] {LS_BYTE = 2'd0, LS_HALF = 2'd1, LS_WORD = 2'd2} ls_size_e;

endpackage

//--- src/ex_top.sv
//##########################################################################
// RV32I execute stage top, control plus ALU, branch and APB load/store
//##########################################################################
`timescale 1ns/1ns
`include "ex_config.svh"

module ex_top (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                valid_i,
    input  logic [31:0]         inst_i,
    input  ex_pkg::word_t       pc_i,
    input  ex_pkg::word_t       rs1_data_i,
    input  ex_pkg::word_t       rs2_data_i,
    output logic                ready_o,
    output logic                wb_valid_o,
    output logic [4:0]          wb_rd_o,
    output ex_pkg::word_t       wb_data_o,
    output logic                jump_o,
    output ex_pkg::word_t       jump_addr_o,
    output logic [`EX_AW-1:0]   paddr_o,
    output logic                psel_o,
    output logic                penable_o,
    output logic                pwrite_o,
    output ex_pkg::word_t       pwdata_o,
    output logic [`EX_STRB-1:0] pstrb_o,
    input  ex_pkg::word_t       prdata_i,
    input  logic                pready_i
);

    alu_if i_alu_if ();
    br_if  i_br_if ();
    lsu_if i_lsu_if ();

    ex_ctrl i_ctrl (
        .clk, .rst_n_i, .valid_i, .inst_i, .pc_i, .rs1_data_i, .rs2_data_i,
        .ready_o, .wb_valid_o, .wb_rd_o, .wb_data_o, .jump_o, .jump_addr_o,
        .alu (i_alu_if.ctrl),
        .br  (i_br_if.ctrl),
        .lsu (i_lsu_if.ctrl)
    );

    ex_alu    i_alu    (.alu (i_alu_if.alu));
    ex_branch i_branch (.br (i_br_if.branch));

    ex_lsu i_lsu (
        .clk, .rst_n_i,
        .lsu (i_lsu_if.lsu),
        .paddr_o, .psel_o, .penable_o, .pwrite_o, .pwdata_o, .pstrb_o,
        .prdata_i, .pready_i
    );

endmodule
